// ==== Makefile ====
# Verilator build and run for the SPI host testbench

VERILATOR ?= verilator
TOP       ?= spi_host_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# Pass only when the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== flist.f ====
hw/spi_host_pkg.sv
hw/spi_host_window.sv
hw/spi_host_fifo.sv
hw/spi_host_timer.sv
hw/spi_host_shift.sv
hw/spi_host_fsm.sv
hw/spi_host_top.sv
verif/spi_host_asserts.sv
verif/spi_host_tb.sv

// ==== hw/spi_host_fifo.sv ====
module spi_host_fifo (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      push_i,
  input  spi_host_pkg::fifo_entry_t entry_i,
  input  logic                      pop_i,
  output spi_host_pkg::fifo_entry_t head_o,
  output logic                      full_o,
  output logic                      empty_o,
  output logic                      err_o
);
  import spi_host_pkg::*;

  fifo_entry_t       mem_q [FifoDepth];
  logic [FifoAw-1:0] wr_q;
  logic [FifoAw-1:0] rd_q;
  logic [FifoAw:0]   cnt_q;
  logic              do_push;
  logic              do_pop;

  assign full_o  = cnt_q == (FifoAw + 1)'(FifoDepth);
  assign empty_o = cnt_q == '0;

  // Overflowing push dropped, underflowing pop ignored
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // Head visible one cycle after the write
  assign head_o = mem_q[rd_q];

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_q] <= entry_i;
    end
  end

  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_q  <= '0;
      rd_q  <= '0;
      cnt_q <= '0;
    end else begin
      if (do_push) begin
        wr_q <= wr_q + 1'b1;
      end
      if (do_pop) begin
        rd_q <= rd_q + 1'b1;
      end
      cnt_q <= cnt_q + (FifoAw + 1)'(do_push) - (FifoAw + 1)'(do_pop);
    end
  end

  // Sticky error, cleared only by reset
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      err_o <= 1'b0;
    end else if ((push_i & full_o) | (pop_i & empty_o)) begin
      err_o <= 1'b1;
    end
  end

endmodule

// ==== hw/spi_host_fsm.sv ====
module spi_host_fsm (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  spi_host_pkg::spi_cmd_t cmd_i,
  input  logic                   tx_empty_i,
  input  logic                   rx_full_i,
  input  logic                   none_i,
  input  logic                   byte_end_i,
  output logic                   load_o,
  output logic                   tx_pop_o,
  output logic                   flush_o,
  output logic                   run_o,
  output logic                   csb_o,
  output logic                   busy_o,
  output logic                   done_o
);
  import spi_host_pkg::*;

  fsm_state_t      state_q;
  fsm_state_t      state_d;
  len_t            rem_q;
  logic [DivW-1:0] hold_q;
  logic            can_go;
  logic            fetch_st;
  logic            hold_last;
  logic            last_byte;

  // Data to send and room to receive
  assign can_go    = ~tx_empty_i & ~rx_full_i;
  assign fetch_st  = (state_q == CsSetup) || (state_q == Fetch);
  assign hold_last = hold_q == DivW'(ClkHalf - 1);
  assign last_byte = rem_q == len_t'(1);

  always_comb begin
    state_d  = state_q;
    load_o   = 1'b0;
    tx_pop_o = 1'b0;
    unique case (state_q)
      Idle: begin
        // Zero length still toggles chip select
        if (cmd_i.start) begin
          state_d = (cmd_i.len == '0) ? CsHold : CsSetup;
        end
      end
      CsSetup, Fetch: begin
        state_d = Fetch;
        if (can_go && none_i) begin
          // Word without strobes, drop it
          tx_pop_o = 1'b1;
        end else if (can_go) begin
          load_o  = 1'b1;
          state_d = Shift;
        end
      end
      Shift: begin
        if (byte_end_i) begin
          if (last_byte) begin
            state_d = CsHold;
          end else if (can_go && !none_i) begin
            // Back to back bytes, SCK keeps running
            load_o = 1'b1;
          end else begin
            tx_pop_o = can_go & none_i;
            state_d  = Fetch;
          end
        end
      end
      CsHold: begin
        if (hold_last) begin
          state_d = Idle;
        end
      end
      default: state_d = Idle;
    endcase
  end

  // SCK runs from the load cycle on
  assign run_o   = (state_q == Shift) | (fetch_st & load_o);
  assign csb_o   = state_q == Idle;
  assign busy_o  = state_q != Idle;
  // Partial RX word goes out as chip select hold starts
  assign flush_o = (state_q == CsHold) & (hold_q == '0);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= Idle;
      rem_q   <= '0;
      hold_q  <= '0;
      done_o  <= 1'b0;
    end else begin
      state_q <= state_d;
      // Byte countdown
      if (state_q == Idle && cmd_i.start) begin
        rem_q <= cmd_i.len;
      end else if (state_q == Shift && byte_end_i) begin
        rem_q <= rem_q - 1'b1;
      end
      hold_q <= (state_q == CsHold) ? hold_q + 1'b1 : '0;
      // Lines up with chip select release
      done_o <= (state_q == CsHold) & hold_last;
    end
  end

endmodule

// ==== hw/spi_host_pkg.sv ====
package spi_host_pkg;

  // Register bus geometry
  localparam int BlockAw    = 6;
  localparam int DataW      = 32;
  localparam int ByteMaskW  = DataW / 8;
  localparam int DataOffset = 6'h24;

  // FIFO sizing
  localparam int FifoDepth = 8;
  localparam int FifoAw    = $clog2(FifoDepth);

  // SCK timing, system cycles per half period
  localparam int ClkHalf = 2;
  localparam int DivW    = $clog2(ClkHalf + 1);

  // Byte and lane bookkeeping
  localparam int ByteBitsW = 3;
  localparam int ByteIdxW  = $clog2(ByteMaskW);

  // Command length in bytes
  localparam int LenW = 9;

  typedef logic [BlockAw-1:0]   addr_t;
  typedef logic [DataW-1:0]     word_t;
  typedef logic [ByteMaskW-1:0] strb_t;
  typedef logic [LenW-1:0]      len_t;

  // Register bus request
  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    word_t wdata;
    strb_t wstrb;
  } reg_req_t;

  // Register bus response
  typedef struct packed {
    word_t rdata;
    logic  error;
    logic  ready;
  } reg_rsp_t;

  // One FIFO slot, data plus byte enables
  typedef struct packed {
    word_t word;
    strb_t strb;
  } fifo_entry_t;

  // Transfer command, start is a single cycle pulse
  typedef struct packed {
    logic start;
    len_t len;
  } spi_cmd_t;

  typedef enum logic [2:0] {
    Idle,
    CsSetup,
    Fetch,
    Shift,
    CsHold
  } fsm_state_t;

endpackage

// ==== hw/spi_host_shift.sv ====
module spi_host_shift (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  spi_host_pkg::fifo_entry_t tx_head_i,
  input  logic                      load_i,
  input  logic                      sample_i,
  input  logic                      shift_i,
  input  logic                      byte_end_i,
  input  logic                      flush_i,
  input  logic                      sd_i,
  output logic                      sd_o,
  output logic                      word_done_o,
  output logic                      none_o,
  output logic                      rx_push_o,
  output spi_host_pkg::fifo_entry_t rx_entry_o
);
  import spi_host_pkg::*;

  strb_t               used_q;
  strb_t               remain;
  strb_t               pick;
  logic [ByteIdxW-1:0] idx;
  logic [7:0]          tx_sr_q;
  logic [7:0]          rx_sr_q;
  word_t               rx_word_q;
  word_t               rx_word_d;
  strb_t               rx_strb_q;
  strb_t               rx_strb_d;
  logic [ByteIdxW-1:0] lane_q;

  // Strobed bytes of the head word not yet sent
  assign remain = tx_head_i.strb & ~used_q;
  assign none_o = remain == '0;

  // Lowest remaining lane goes first
  always_comb begin
    idx = '0;
    for (int i = ByteMaskW - 1; i >= 0; i--) begin
      if (remain[i]) begin
        idx = ByteIdxW'(i);
      end
    end
  end

  assign pick = strb_t'(1) << idx;

  // Last strobed byte taken, head word can go
  assign word_done_o = load_i & ((remain & ~pick) == '0);

  // MSB first, mode 0
  assign sd_o = tx_sr_q[7];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      used_q  <= '0;
      tx_sr_q <= '0;
    end else if (load_i) begin
      used_q  <= word_done_o ? '0 : (used_q | pick);
      tx_sr_q <= tx_head_i.word[idx*8 +: 8];
    end else if (shift_i) begin
      tx_sr_q <= {tx_sr_q[6:0], 1'b0};
    end
  end

  // Receive shifter, filled on rising SCK
  always_ff @(posedge clk_i) begin
    if (sample_i) begin
      rx_sr_q <= {rx_sr_q[6:0], sd_i};
    end
  end

  // Completed byte merged into the next free lane
  always_comb begin
    rx_word_d = rx_word_q;
    rx_strb_d = rx_strb_q;
    if (byte_end_i) begin
      rx_word_d[lane_q*8 +: 8] = rx_sr_q;
      rx_strb_d[lane_q]        = 1'b1;
    end
  end

  // Full word or end of command
  assign rx_push_o = (byte_end_i & (lane_q == '1)) | (flush_i & (rx_strb_d != '0));

  // Unfilled lanes read as zero
  always_comb begin
    for (int b = 0; b < ByteMaskW; b++) begin
      rx_entry_o.word[b*8 +: 8] = rx_word_d[b*8 +: 8] & {8{rx_strb_d[b]}};
    end
    rx_entry_o.strb = rx_strb_d;
  end

  always_ff @(posedge clk_i) begin
    rx_word_q <= rx_word_d;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i || rx_push_o) begin
      rx_strb_q <= '0;
      lane_q    <= '0;
    end else begin
      rx_strb_q <= rx_strb_d;
      lane_q    <= lane_q + ByteIdxW'(byte_end_i);
    end
  end

endmodule

// ==== hw/spi_host_timer.sv ====
module spi_host_timer (
  input  logic clk_i,
  input  logic rst_i,
  input  logic run_i,
  output logic sck_o,
  output logic sample_o,
  output logic shift_o,
  output logic byte_end_o
);
  import spi_host_pkg::*;

  logic [DivW-1:0]      div_q;
  logic [ByteBitsW-1:0] edge_q;
  logic                 sck_q;
  logic                 half_tick;

  // One pulse per SCK half period
  assign half_tick = run_i & (div_q == DivW'(ClkHalf - 1));

  // Low SCK about to rise, sample point
  assign sample_o = half_tick & ~sck_q;
  // High SCK about to fall, shift point
  assign shift_o  = half_tick & sck_q;
  // Eighth falling edge closes the byte
  assign byte_end_o = shift_o & (edge_q == '1);

  assign sck_o = sck_q;

  // Stopping the clock parks SCK low and restarts both counts
  always_ff @(posedge clk_i) begin
    if (rst_i || !run_i) begin
      div_q  <= '0;
      edge_q <= '0;
      sck_q  <= 1'b0;
    end else begin
      if (half_tick) begin
        div_q <= '0;
        sck_q <= ~sck_q;
      end else begin
        div_q <= div_q + 1'b1;
      end
      // Falling edge count, wraps at byte end
      if (shift_o) begin
        edge_q <= edge_q + 1'b1;
      end
    end
  end

endmodule

// ==== hw/spi_host_top.sv ====
module spi_host_top (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  spi_host_pkg::reg_req_t tx_win_i,
  output spi_host_pkg::reg_rsp_t tx_win_o,
  input  spi_host_pkg::reg_req_t rx_win_i,
  output spi_host_pkg::reg_rsp_t rx_win_o,
  input  spi_host_pkg::spi_cmd_t cmd_i,
  input  logic                   sd_i,
  output logic                   sck_o,
  output logic                   csb_o,
  output logic                   sd_o,
  output logic                   busy_o,
  output logic                   done_o,
  output logic                   tx_overflow_o,
  output logic                   rx_underflow_o
);
  import spi_host_pkg::*;

  fifo_entry_t tx_entry;
  fifo_entry_t tx_head;
  fifo_entry_t rx_entry;
  fifo_entry_t rx_head;
  logic        tx_push;
  logic        tx_pop;
  logic        tx_full;
  logic        tx_empty;
  logic        rx_push;
  logic        rx_pop;
  logic        rx_full;
  logic        rx_empty;
  logic        fsm_pop;
  logic        word_done;
  logic        none;
  logic        load;
  logic        flush;
  logic        run;
  logic        sample;
  logic        shift;
  logic        byte_end;

  // TX head leaves on its last byte or when it has no strobes
  assign tx_pop = fsm_pop | word_done;

  spi_host_window u_window (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .tx_win_i   (tx_win_i),
    .tx_win_o   (tx_win_o),
    .rx_win_i   (rx_win_i),
    .rx_win_o   (rx_win_o),
    .tx_push_o  (tx_push),
    .tx_entry_o (tx_entry),
    .rx_pop_o   (rx_pop),
    .rx_head_i  (rx_head.word),
    .rx_empty_i (rx_empty)
  );

  spi_host_fifo u_tx_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (tx_push),
    .entry_i (tx_entry),
    .pop_i   (tx_pop),
    .head_o  (tx_head),
    .full_o  (tx_full),
    .empty_o (tx_empty),
    .err_o   (tx_overflow_o)
  );

  spi_host_fifo u_rx_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (rx_push),
    .entry_i (rx_entry),
    .pop_i   (rx_pop),
    .head_o  (rx_head),
    .full_o  (rx_full),
    .empty_o (rx_empty),
    .err_o   (rx_underflow_o)
  );

  spi_host_timer u_timer (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .run_i      (run),
    .sck_o      (sck_o),
    .sample_o   (sample),
    .shift_o    (shift),
    .byte_end_o (byte_end)
  );

  spi_host_shift u_shift (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .tx_head_i   (tx_head),
    .load_i      (load),
    .sample_i    (sample),
    .shift_i     (shift),
    .byte_end_i  (byte_end),
    .flush_i     (flush),
    .sd_i        (sd_i),
    .sd_o        (sd_o),
    .word_done_o (word_done),
    .none_o      (none),
    .rx_push_o   (rx_push),
    .rx_entry_o  (rx_entry)
  );

  spi_host_fsm u_fsm (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .cmd_i      (cmd_i),
    .tx_empty_i (tx_empty),
    .rx_full_i  (rx_full),
    .none_i     (none),
    .byte_end_i (byte_end),
    .load_o     (load),
    .tx_pop_o   (fsm_pop),
    .flush_o    (flush),
    .run_o      (run),
    .csb_o      (csb_o),
    .busy_o     (busy_o),
    .done_o     (done_o)
  );

endmodule

// ==== hw/spi_host_window.sv ====
module spi_host_window (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  spi_host_pkg::reg_req_t   tx_win_i,
  output spi_host_pkg::reg_rsp_t   tx_win_o,
  input  spi_host_pkg::reg_req_t   rx_win_i,
  output spi_host_pkg::reg_rsp_t   rx_win_o,
  output logic                     tx_push_o,
  output spi_host_pkg::fifo_entry_t tx_entry_o,
  output logic                     rx_pop_o,
  input  spi_host_pkg::word_t      rx_head_i,
  input  logic                     rx_empty_i
);
  import spi_host_pkg::*;

  logic tx_hit;
  logic tx_err;
  logic rx_err;

  // Only the data window offset is decoded
  assign tx_hit = tx_win_i.addr == addr_t'(DataOffset);

  // TX side is write only
  assign tx_err = tx_win_i.valid & (~tx_win_i.write | ~tx_hit);
  // RX side rejects writes outside the window
  assign rx_err = rx_win_i.valid & rx_win_i.write &
                  (rx_win_i.addr != addr_t'(DataOffset));

  // Push strobe, same cycle as the bus access
  assign tx_push_o        = tx_win_i.valid & tx_win_i.write & tx_hit;
  assign tx_entry_o.word  = tx_win_i.wdata;
  assign tx_entry_o.strb  = tx_win_i.wstrb;

  // Nothing to return on the TX side
  assign tx_win_o.rdata = '0;
  assign tx_win_o.error = tx_err;
  assign tx_win_o.ready = 1'b1;

  // Any read of the RX window consumes the head entry
  assign rx_pop_o = rx_win_i.valid & ~rx_win_i.write;

  // Empty FIFO reads as zero
  assign rx_win_o.rdata = rx_empty_i ? '0 : rx_head_i;
  assign rx_win_o.error = rx_err;
  assign rx_win_o.ready = 1'b1;

endmodule

// ==== verif/spi_host_asserts.sv ====
module spi_host_asserts (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  spi_host_pkg::reg_req_t tx_win_i,
  input  spi_host_pkg::reg_rsp_t tx_rsp_i,
  input  spi_host_pkg::reg_req_t rx_win_i,
  input  spi_host_pkg::reg_rsp_t rx_rsp_i,
  input  spi_host_pkg::spi_cmd_t cmd_i,
  input  logic                   sck_i,
  input  logic                   csb_i,
  input  logic                   busy_i,
  input  logic                   done_i,
  input  logic                   run_i,
  input  logic                   tx_push_i,
  input  logic                   tx_full_i,
  input  logic                   tx_empty_i,
  input  logic                   rx_pop_i,
  input  logic                   rx_empty_i,
  input  logic                   tx_overflow_i,
  input  logic                   rx_underflow_i
);
  timeunit 1ns;
  timeprecision 100ps;

  import spi_host_pkg::*;

  // Failing assertions, polled by the testbench
  int unsigned fail_cnt = 0;

  // Everything idle and clean the cycle after reset
  a_reset_state: assert property (@(posedge clk_i)
    rst_i |=> csb_i && !sck_i && !busy_i && !done_i && !tx_overflow_i && !rx_underflow_i)
    else begin fail_cnt++; $error("Outputs not idle after reset"); end

  // No clock while deselected
  a_sck_idle: assert property (@(posedge clk_i) disable iff (rst_i)
    csb_i |-> !sck_i)
    else begin fail_cnt++; $error("SCK active with chip select high"); end

  // Start in idle selects the device on the next cycle
  a_start_cs: assert property (@(posedge clk_i) disable iff (rst_i)
    cmd_i.start && !busy_i |=> busy_i && !csb_i)
    else begin fail_cnt++; $error("Start pulse did not select the device"); end

  // Busy ends only in the done cycle
  a_busy_end: assert property (@(posedge clk_i) disable iff (rst_i)
    $fell(busy_i) |-> done_i)
    else begin fail_cnt++; $error("busy dropped without done"); end

  // Single cycle done, same cycle as chip select release
  a_done_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    done_i |=> !done_i)
    else begin fail_cnt++; $error("done longer than one cycle"); end

  a_done_csb: assert property (@(posedge clk_i) disable iff (rst_i)
    done_i |-> $rose(csb_i))
    else begin fail_cnt++; $error("done not aligned with chip select rise"); end

  // Stall on empty TX keeps SCK parked low, CS held
  a_tx_stall: assert property (@(posedge clk_i) disable iff (rst_i)
    busy_i && tx_empty_i && !run_i |-> !sck_i && !csb_i)
    else begin fail_cnt++; $error("SCK moved or CS released during stall"); end

  // Decode errors in the access cycle
  a_tx_read_err: assert property (@(posedge clk_i) disable iff (rst_i)
    tx_win_i.valid && !tx_win_i.write |-> tx_rsp_i.error)
    else begin fail_cnt++; $error("TX read without error"); end

  a_tx_addr_err: assert property (@(posedge clk_i) disable iff (rst_i)
    tx_win_i.valid && tx_win_i.addr != addr_t'(DataOffset) |-> tx_rsp_i.error)
    else begin fail_cnt++; $error("TX access outside window without error"); end

  a_rx_addr_err: assert property (@(posedge clk_i) disable iff (rst_i)
    rx_win_i.valid && rx_win_i.write && rx_win_i.addr != addr_t'(DataOffset)
      |-> rx_rsp_i.error)
    else begin fail_cnt++; $error("RX write outside window without error"); end

  a_tx_good: assert property (@(posedge clk_i) disable iff (rst_i)
    tx_win_i.valid && tx_win_i.write && tx_win_i.addr == addr_t'(DataOffset)
      |-> !tx_rsp_i.error)
    else begin fail_cnt++; $error("Valid TX write flagged as error"); end

  a_ready: assert property (@(posedge clk_i) disable iff (rst_i)
    tx_rsp_i.ready && rx_rsp_i.ready)
    else begin fail_cnt++; $error("Window not ready"); end

  // Overflow and underflow, set and sticky
  a_ovf_set: assert property (@(posedge clk_i) disable iff (rst_i)
    tx_push_i && tx_full_i |=> tx_overflow_i)
    else begin fail_cnt++; $error("Push into full TX FIFO not flagged"); end

  a_ovf_sticky: assert property (@(posedge clk_i) disable iff (rst_i)
    tx_overflow_i |=> tx_overflow_i)
    else begin fail_cnt++; $error("TX overflow flag dropped"); end

  a_udf_zero: assert property (@(posedge clk_i) disable iff (rst_i)
    rx_pop_i && rx_empty_i |-> rx_rsp_i.rdata == '0)
    else begin fail_cnt++; $error("Empty RX read returned data"); end

  a_udf_set: assert property (@(posedge clk_i) disable iff (rst_i)
    rx_pop_i && rx_empty_i |=> rx_underflow_i)
    else begin fail_cnt++; $error("Pop from empty RX FIFO not flagged"); end

  a_udf_sticky: assert property (@(posedge clk_i) disable iff (rst_i)
    rx_underflow_i |=> rx_underflow_i)
    else begin fail_cnt++; $error("RX underflow flag dropped"); end

endmodule

bind spi_host_top spi_host_asserts u_asserts (
  .clk_i          (clk_i),
  .rst_i          (rst_i),
  .tx_win_i       (tx_win_i),
  .tx_rsp_i       (tx_win_o),
  .rx_win_i       (rx_win_i),
  .rx_rsp_i       (rx_win_o),
  .cmd_i          (cmd_i),
  .sck_i          (sck_o),
  .csb_i          (csb_o),
  .busy_i         (busy_o),
  .done_i         (done_o),
  .run_i          (run),
  .tx_push_i      (tx_push),
  .tx_full_i      (tx_full),
  .tx_empty_i     (tx_empty),
  .rx_pop_i       (rx_pop),
  .rx_empty_i     (rx_empty),
  .tx_overflow_i  (tx_overflow_o),
  .rx_underflow_i (rx_underflow_o)
);

// ==== verif/spi_host_tb.sv ====
module spi_host_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import spi_host_pkg::*;

  // 34 bytes at 16*ClkHalf cycles each, large margin for stalls and bus traffic
  localparam int unsigned TimeoutCycles = 20000;

  logic        clk;
  logic        rst;
  reg_req_t    tx_req;
  reg_rsp_t    tx_rsp;
  reg_req_t    rx_req;
  reg_rsp_t    rx_rsp;
  spi_cmd_t    cmd;
  logic        sd_loop;
  logic        sck;
  logic        csb;
  logic        busy;
  logic        done;
  logic        tx_ovf;
  logic        rx_udf;
  int          seed;
  int unsigned cycle_cnt = 0;
  int unsigned done_cnt = 0;
  logic [7:0]  byte_q[$];
  word_t       exp_q[$];

  // sd_o looped straight back into sd_i
  spi_host_top i_dut (
    .clk_i          (clk),
    .rst_i          (rst),
    .tx_win_i       (tx_req),
    .tx_win_o       (tx_rsp),
    .rx_win_i       (rx_req),
    .rx_win_o       (rx_rsp),
    .cmd_i          (cmd),
    .sd_i           (sd_loop),
    .sck_o          (sck),
    .csb_o          (csb),
    .sd_o           (sd_loop),
    .busy_o         (busy),
    .done_o         (done),
    .tx_overflow_o  (tx_ovf),
    .rx_underflow_o (rx_udf)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped at first failure");
  endtask

  // Done count, timeout and assertion watch, all away from the active edge
  always @(negedge clk) begin
    cycle_cnt++;
    if (done) begin
      done_cnt++;
    end
    if (cycle_cnt >= TimeoutCycles) begin
      report_failure($sformatf("Timeout after %0d cycles, transfer never finished",
                               cycle_cnt));
    end
    if (i_dut.u_asserts.fail_cnt != 0) begin
      report_failure("A protocol assertion failed");
    end
  end

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      report_failure($sformatf("MISMATCH at %0t ns: %s read %08h, expected %08h",
                               $time, what, got, exp));
    end
  endtask

  // Inputs change 2 ns after the rising edge
  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic idle(input int n);
    repeat (n) step();
  endtask

  task automatic tx_write(input addr_t addr, input word_t data, input strb_t strb);
    tx_req.valid = 1'b1;
    tx_req.write = 1'b1;
    tx_req.addr  = addr;
    tx_req.wdata = data;
    tx_req.wstrb = strb;
    step();
    tx_req = '0;
  endtask

  task automatic tx_read();
    tx_req.valid = 1'b1;
    tx_req.write = 1'b0;
    tx_req.addr  = addr_t'(DataOffset);
    step();
    tx_req = '0;
  endtask

  task automatic rx_write(input addr_t addr, input word_t data);
    rx_req.valid = 1'b1;
    rx_req.write = 1'b1;
    rx_req.addr  = addr;
    rx_req.wdata = data;
    rx_req.wstrb = '1;
    step();
    rx_req = '0;
  endtask

  // rdata is combinational, taken mid cycle
  task automatic rx_read(output word_t data);
    rx_req.valid = 1'b1;
    rx_req.write = 1'b0;
    rx_req.addr  = addr_t'(DataOffset);
    @(negedge clk);
    data = rx_rsp.rdata;
    step();
    rx_req = '0;
  endtask

  task automatic start_cmd(input int n);
    cmd.start = 1'b1;
    cmd.len   = len_t'(n);
    step();
    cmd = '0;
  endtask

  // Bounded by the global timeout
  task automatic wait_done(input int unsigned exp_cnt);
    do begin
      @(negedge clk);
    end while (!done);
    step();
    idle(2);
    check_word(word_t'(done_cnt), word_t'(exp_cnt), "done pulse count");
  endtask

  // Strobed bytes in lane order form the serial stream
  task automatic queue_bytes(input word_t data, input strb_t strb);
    for (int b = 0; b < ByteMaskW; b++) begin
      if (strb[b]) begin
        byte_q.push_back(data[b*8 +: 8]);
      end
    end
  endtask

  // Stream repacked from lane 0 up, tail lanes zero
  task automatic bytes_to_words();
    word_t w;
    int    lane;
    w    = '0;
    lane = 0;
    while (byte_q.size() > 0) begin
      w[lane*8 +: 8] = byte_q.pop_front();
      lane++;
      if (lane == ByteMaskW) begin
        exp_q.push_back(w);
        w    = '0;
        lane = 0;
      end
    end
    if (lane != 0) begin
      exp_q.push_back(w);
    end
  endtask

  task automatic read_and_check(input string what);
    word_t got;
    int    idx;
    idx = 0;
    while (exp_q.size() > 0) begin
      rx_read(got);
      check_word(got, exp_q.pop_front(), $sformatf("%s word %0d", what, idx));
      idx++;
    end
  endtask

  initial begin
    word_t data;
    strb_t strb;
    int    nbytes;
    seed   = 34;
    rst    = 1'b1;
    tx_req = '0;
    rx_req = '0;
    cmd    = '0;
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;
    // Reset state held by the assertions while idle
    idle(10);

    // Full strobes, 4 words, 16 bytes
    for (int i = 0; i < 4; i++) begin
      data = $random(seed);
      tx_write(addr_t'(DataOffset), data, 4'hf);
      queue_bytes(data, 4'hf);
    end
    bytes_to_words();
    start_cmd(16);
    wait_done(1);
    read_and_check("full strobe");

    // Sparse strobes, last RX word partial
    nbytes = 0;
    for (int i = 0; i < 5; i++) begin
      data = $random(seed);
      strb = (i % 2 == 0) ? 4'b0101 : 4'b0011;
      tx_write(addr_t'(DataOffset), data, strb);
      queue_bytes(data, strb);
      nbytes += $countones(strb);
    end
    bytes_to_words();
    start_cmd(nbytes);
    wait_done(2);
    read_and_check("sparse strobe");

    // Command first, TX FIFO empty, transfer stalls
    start_cmd(8);
    idle(40);
    for (int i = 0; i < 2; i++) begin
      data = $random(seed);
      tx_write(addr_t'(DataOffset), data, 4'hf);
      queue_bytes(data, 4'hf);
    end
    bytes_to_words();
    wait_done(3);
    read_and_check("stalled");

    // Decode errors, checked in the access cycle
    tx_read();
    tx_write(addr_t'(DataOffset + 4), $random(seed), 4'hf);
    rx_write(addr_t'(0), $random(seed));
    idle(4);

    // One write past depth overflows
    for (int i = 0; i < FifoDepth + 1; i++) begin
      tx_write(addr_t'(DataOffset), $random(seed), 4'hf);
    end
    idle(2);
    rx_read(data);
    check_word(data, '0, "empty RX window");
    idle(20);
    check_word(word_t'({tx_ovf, rx_udf}), word_t'(2'b11), "sticky error flags");

    // Only reset clears the flags
    rst = 1'b1;
    idle(10);
    rst = 1'b0;
    idle(5);
    check_word(word_t'({tx_ovf, rx_udf}), '0, "error flags after reset");

    if (i_dut.u_asserts.fail_cnt == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      report_failure("Assertion failures were counted during the run");
    end
  end

endmodule
